/* logic/soc_pnp_pkg.sv */
package soc_pnp_pkg;

    // soc identity and capability
    localparam logic [31:0] HW_ID        = 32'h20240611;
    localparam int          CPU_MAX      = 1;
    localparam int          L2CACHE_ENA  = 1;
    localparam int          PLIC_IRQ_MAX = 127;

    localparam logic [15:0] VENDOR_ID        = 16'h00f1;
    localparam logic [15:0] PNP_DEVICE_ID    = 16'h0071;
    localparam logic [1:0]  DESCR_TYPE_SLAVE = 2'd2;
    localparam logic [7:0]  DESCR_SIZE       = 8'd32;   // bytes per descriptor

    // register map, in 32-bit word indices
    localparam int WORD_IDX_W         = 10;             // paddr[11:2]
    localparam int HWID_WORD          = 0;              // also the doorbell
    localparam int FWID_WORD          = 1;
    localparam int CAP_WORD           = 2;
    localparam int SCRATCH_BASE_WORD  = 4;
    localparam int SCRATCH_WORDS      = 12;
    localparam int CFG_BASE_WORD      = 16;
    localparam int CFG_SLOTS          = 3;
    localparam int CFG_WORDS_PER_SLOT = 8;
    localparam int CFG_WORD_BITS      = $clog2(CFG_WORDS_PER_SLOT);
    localparam int CFG_IDX_W          = 5;              // table word index width
    localparam int LAST_WORD          = CFG_BASE_WORD + CFG_WORDS_PER_SLOT * CFG_SLOTS - 1;

    typedef struct packed {
        logic [31:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_in_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_out_t;

    typedef struct packed {
        logic [63:0] slot_base;                         // from interconnect
        logic [63:0] slot_end;
    } map_info_t;

    typedef struct packed {
        logic [1:0]  descr_type;
        logic [7:0]  descr_size;
        logic [15:0] vid;
        logic [15:0] did;
        logic [63:0] addr_start;
        logic [63:0] addr_end;
    } pnp_descr_t;

    // own descriptor of this block, same layout as a table entry
    typedef struct packed {
        logic [1:0]  descr_type;
        logic [7:0]  descr_size;
        logic [15:0] vid;
        logic [15:0] did;
        logic [63:0] addr_start;
        logic [63:0] addr_end;
    } dev_config_t;

    typedef struct packed {
        logic                  valid;                   // one-cycle strobe
        logic [WORD_IDX_W-1:0] idx;
        logic                  write;
        logic [31:0]           wdata;
    } pnp_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
        logic        err;
    } pnp_resp_t;

    typedef pnp_descr_t [CFG_SLOTS-1:0] pnp_descr_vec_t;

endpackage

/* logic/apb_slave_ctrl.sv */
module apb_slave_ctrl (
    input  logic                     i_clk,
    input  logic                     i_nrst,
    input  soc_pnp_pkg::apb_in_t     i_apbi,
    input  soc_pnp_pkg::map_info_t   i_mapinfo,
    input  soc_pnp_pkg::pnp_resp_t   i_resp,
    output soc_pnp_pkg::apb_out_t    o_apbo,
    output soc_pnp_pkg::pnp_req_t    o_req,
    output soc_pnp_pkg::dev_config_t o_cfg
);

    typedef enum logic [1:0] {
        ST_IDLE,                                        // waiting for setup phase
        ST_WAIT,                                        // request strobe out
        ST_DONE                                         // response back, pready
    } state_t;

    state_t                                state;
    state_t                                state_nxt;
    logic                                  setup;
    logic                                  ready;
    logic [soc_pnp_pkg::WORD_IDX_W-1:0]    req_idx;
    logic                                  req_write;
    logic [31:0]                           req_wdata;

    // setup phase seen only from idle, so one transfer in flight at a time
    assign setup = (state == ST_IDLE) && i_apbi.psel && !i_apbi.penable;
    assign ready = (state == ST_DONE) && i_resp.valid;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (setup) begin
                    state_nxt = ST_WAIT;
                end
            end
            ST_WAIT: begin
                state_nxt = ST_DONE;                    // regs answer next edge
            end
            ST_DONE: begin
                if (i_resp.valid) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // request payload captured in the setup cycle
    always_ff @(posedge i_clk) begin
        if (setup) begin
            req_idx   <= i_apbi.paddr[11:2];            // word index in 4 KB window
            req_write <= i_apbi.pwrite;
            req_wdata <= i_apbi.pwdata;
        end
    end

    always_comb begin
        o_req.valid = (state == ST_WAIT);               // first access cycle only
        o_req.idx   = req_idx;
        o_req.write = req_write;
        o_req.wdata = req_wdata;
    end

    always_comb begin
        o_apbo.prdata  = i_resp.rdata;
        o_apbo.pready  = ready;
        o_apbo.pslverr = ready && i_resp.err;
    end

    // own descriptor for the interconnect
    always_comb begin
        o_cfg.descr_type = soc_pnp_pkg::DESCR_TYPE_SLAVE;
        o_cfg.descr_size = soc_pnp_pkg::DESCR_SIZE;
        o_cfg.vid        = soc_pnp_pkg::VENDOR_ID;
        o_cfg.did        = soc_pnp_pkg::PNP_DEVICE_ID;
        o_cfg.addr_start = i_mapinfo.slot_base;
        o_cfg.addr_end   = i_mapinfo.slot_end;
    end

endmodule

/* logic/pnp_regs.sv */
module pnp_regs (
    input  logic                               i_clk,
    input  logic                               i_nrst,
    input  soc_pnp_pkg::pnp_req_t              i_req,
    input  logic [31:0]                        i_cfg_word,
    output logic [soc_pnp_pkg::CFG_IDX_W-1:0]  o_cfg_idx,
    output soc_pnp_pkg::pnp_resp_t             o_resp,
    output logic                               o_irq
);

    int                                 widx;
    logic [soc_pnp_pkg::WORD_IDX_W-1:0] cfg_off;
    logic [3:0]                         scr_sel;
    logic                               is_scratch;
    logic                               wr_en;
    logic [31:0]                        cap_word;
    logic [31:0]                        rd_word;
    logic                               rd_err;

    logic [31:0]                        fw_id;
    logic [31:0]                        scratch [soc_pnp_pkg::SCRATCH_WORDS];
    logic                               irq;
    logic                               resp_valid;
    logic [31:0]                        resp_rdata;
    logic                               resp_err;

    assign widx       = int'(i_req.idx);
    assign wr_en      = i_req.valid && i_req.write;
    assign is_scratch = (widx >= soc_pnp_pkg::SCRATCH_BASE_WORD) &&
                        (widx <  soc_pnp_pkg::SCRATCH_BASE_WORD + soc_pnp_pkg::SCRATCH_WORDS);
    assign scr_sel    = 4'(widx - soc_pnp_pkg::SCRATCH_BASE_WORD);

    // table offset, only meaningful inside the descriptor range
    assign cfg_off   = i_req.idx - soc_pnp_pkg::WORD_IDX_W'(soc_pnp_pkg::CFG_BASE_WORD);
    assign o_cfg_idx = cfg_off[soc_pnp_pkg::CFG_IDX_W-1:0];

    assign cap_word = {
        4'(soc_pnp_pkg::CPU_MAX),                       // [31:28]
        3'd0,
        1'(soc_pnp_pkg::L2CACHE_ENA),                   // [24]
        8'd0,
        8'(soc_pnp_pkg::CFG_SLOTS),                     // [15:8]
        8'(soc_pnp_pkg::PLIC_IRQ_MAX)                   // [7:0]
    };

    // read data and error select
    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        if (widx == soc_pnp_pkg::HWID_WORD) begin
            rd_word = soc_pnp_pkg::HW_ID;
        end else if (widx == soc_pnp_pkg::FWID_WORD) begin
            rd_word = fw_id;
        end else if (widx == soc_pnp_pkg::CAP_WORD) begin
            rd_word = cap_word;
        end else if (is_scratch) begin
            rd_word = scratch[scr_sel];
        end else if (widx >= soc_pnp_pkg::CFG_BASE_WORD &&
                     widx <= soc_pnp_pkg::LAST_WORD) begin
            rd_word = i_cfg_word;
        end else if (widx > soc_pnp_pkg::LAST_WORD) begin
            rd_err = 1'b1;                              // outside the map
        end
    end

    // writable registers, read-only words ignore writes
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            fw_id <= '0;
            for (int i = 0; i < soc_pnp_pkg::SCRATCH_WORDS; i++) begin
                scratch[i] <= '0;
            end
        end else if (wr_en) begin
            if (widx == soc_pnp_pkg::FWID_WORD) begin
                fw_id <= i_req.wdata;
            end else if (is_scratch) begin
                scratch[scr_sel] <= i_req.wdata;
            end
        end
    end

    // response and doorbell land in the same cycle as pready
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            resp_valid <= 1'b0;
            resp_err   <= 1'b0;
            irq        <= 1'b0;
        end else begin
            resp_valid <= i_req.valid;
            irq        <= wr_en && (widx == soc_pnp_pkg::HWID_WORD);
            if (i_req.valid) begin
                resp_err <= rd_err;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req.valid) begin
            resp_rdata <= rd_word;
        end
    end

    always_comb begin
        o_resp.valid = resp_valid;
        o_resp.rdata = resp_rdata;
        o_resp.err   = resp_err;
    end

    assign o_irq = irq;

endmodule

/* logic/pnp_cfg_table.sv */
module pnp_cfg_table (
    input  soc_pnp_pkg::pnp_descr_vec_t        i_cfg,
    input  logic [soc_pnp_pkg::CFG_IDX_W-1:0]  i_idx,
    output logic [31:0]                        o_word
);

    logic [soc_pnp_pkg::CFG_IDX_W-soc_pnp_pkg::CFG_WORD_BITS-1:0] slot;
    logic [soc_pnp_pkg::CFG_WORD_BITS-1:0]                        word_sel;
    logic                                                         slot_ok;

    assign slot     = i_idx[soc_pnp_pkg::CFG_IDX_W-1:soc_pnp_pkg::CFG_WORD_BITS];
    assign word_sel = i_idx[soc_pnp_pkg::CFG_WORD_BITS-1:0];
    assign slot_ok  = int'(slot) < soc_pnp_pkg::CFG_SLOTS;

    always_comb begin
        soc_pnp_pkg::pnp_descr_t d;

        d = '0;
        if (slot_ok) begin
            d = i_cfg[slot];
        end

        case (word_sel)
            3'd0: begin
                o_word = {22'd0, d.descr_type, d.descr_size};
            end
            3'd1: begin
                o_word = {d.vid, d.did};                // vendor in upper half
            end
            3'd4: begin
                o_word = d.addr_start[31:0];
            end
            3'd5: begin
                o_word = d.addr_start[63:32];
            end
            3'd6: begin
                o_word = d.addr_end[31:0];
            end
            3'd7: begin
                o_word = d.addr_end[63:32];
            end
            default: begin
                o_word = '0;                            // words 2 and 3 reserved
            end
        endcase
    end

endmodule

/* logic/pnp_subsys_top.sv */
module pnp_subsys_top (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  soc_pnp_pkg::apb_in_t        i_apbi,
    input  soc_pnp_pkg::map_info_t      i_mapinfo,
    input  soc_pnp_pkg::pnp_descr_vec_t i_cfg,
    output soc_pnp_pkg::apb_out_t       o_apbo,
    output soc_pnp_pkg::dev_config_t    o_cfg,
    output logic                        o_irq
);

    soc_pnp_pkg::pnp_req_t                req;
    soc_pnp_pkg::pnp_resp_t               resp;
    logic [soc_pnp_pkg::CFG_IDX_W-1:0]    cfg_idx;
    logic [31:0]                          cfg_word;

    apb_slave_ctrl u_ctrl (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_apbi    (i_apbi),
        .i_mapinfo (i_mapinfo),
        .i_resp    (resp),
        .o_apbo    (o_apbo),
        .o_req     (req),
        .o_cfg     (o_cfg)
    );

    pnp_regs u_regs (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_req      (req),
        .i_cfg_word (cfg_word),
        .o_cfg_idx  (cfg_idx),
        .o_resp     (resp),
        .o_irq      (o_irq)
    );

    pnp_cfg_table u_table (
        .i_cfg  (i_cfg),
        .i_idx  (cfg_idx),
        .o_word (cfg_word)
    );

endmodule

/* sim/pnp_props.sv */
module pnp_props (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  soc_pnp_pkg::apb_in_t  i_apbi,
    input  soc_pnp_pkg::apb_out_t i_apbo,
    input  soc_pnp_pkg::pnp_req_t i_req
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;                                 // read by the testbench at the end

    ready_in_access: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_apbo.pready |-> (i_apbi.psel && i_apbi.penable))
    else begin
        $error("pready high outside an access phase");
        fail_count++;
    end

    req_one_cycle: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_req.valid |=> !i_req.valid)
    else begin
        $error("request strobe held for two cycles");
        fail_count++;
    end

    ready_one_cycle: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_apbo.pready |=> !i_apbo.pready)
    else begin
        $error("pready held for two cycles");
        fail_count++;
    end

endmodule

bind apb_slave_ctrl pnp_props u_props (
    .i_clk  (i_clk),
    .i_nrst (i_nrst),
    .i_apbi (i_apbi),
    .i_apbo (o_apbo),
    .i_req  (o_req)
);

/* sim/pnp_checker.sv */
module pnp_checker (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  int                          i_phase,
    input  soc_pnp_pkg::apb_in_t        i_apbi,
    input  soc_pnp_pkg::apb_out_t       i_apbo,
    input  logic                        i_irq,
    input  soc_pnp_pkg::pnp_descr_vec_t i_cfg,
    input  soc_pnp_pkg::map_info_t      i_mapinfo,
    input  soc_pnp_pkg::dev_config_t    i_devcfg,
    output int                          o_xfers,
    output int                          o_data_errs,
    output int                          o_proto_errs
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SLOT_W = $clog2(soc_pnp_pkg::CFG_SLOTS);

    logic [31:0] fw_shadow;
    logic [31:0] scratch_shadow [12];
    int          cycle;
    int          setup_cycle;

    function automatic string test_label(input int phase);
        case (phase)
            1: return "reset_values";
            2: return "rw_registers";
            3: return "descr_table";
            4: return "doorbell";
            5: return "errors_latency";
            default: return "startup";
        endcase
    endfunction

    // expected {pslverr, prdata} of a read from word idx
    function automatic logic [32:0] ref_word(input int idx);
        soc_pnp_pkg::pnp_descr_t d;
        int                      off;
        off = idx - soc_pnp_pkg::CFG_BASE_WORD;
        if (idx > soc_pnp_pkg::LAST_WORD) begin
            return {1'b1, 32'd0};
        end else if (off >= 0) begin
            d = i_cfg[SLOT_W'(off / 8)];
            case (off % 8)
                0: return {1'b0, (32'(d.descr_type) << 8) | 32'(d.descr_size)};
                1: return {1'b0, d.vid, d.did};
                4: return {1'b0, d.addr_start[31:0]};
                5: return {1'b0, d.addr_start[63:32]};
                6: return {1'b0, d.addr_end[31:0]};
                7: return {1'b0, d.addr_end[63:32]};
                default: return '0;                         // reserved words
            endcase
        end else if (idx == 0) begin
            return {1'b0, soc_pnp_pkg::HW_ID};
        end else if (idx == 1) begin
            return {1'b0, fw_shadow};
        end else if (idx == 2) begin
            return {1'b0, (32'(soc_pnp_pkg::CPU_MAX) << 28) | (32'(soc_pnp_pkg::L2CACHE_ENA) << 24)
                        | (32'(soc_pnp_pkg::CFG_SLOTS) << 8) | 32'(soc_pnp_pkg::PLIC_IRQ_MAX)};
        end else if (idx >= 4) begin
            return {1'b0, scratch_shadow[4'(idx - 4)]};
        end
        return '0;                                          // word 3
    endfunction

    always @(posedge i_clk) begin
        int                       idx;
        logic [32:0]              exp;
        logic                     ring;
        soc_pnp_pkg::dev_config_t cfg_exp;
        if (!i_nrst) begin
            fw_shadow = '0;
            for (int i = 0; i < 12; i++) begin
                scratch_shadow[i] = '0;
            end
            cycle        = 0;
            setup_cycle  = 0;
            o_xfers      = 0;
            o_data_errs  = 0;
            o_proto_errs = 0;
        end else begin
            idx = int'(i_apbi.paddr[11:2]);
            if (i_apbi.psel && !i_apbi.penable) begin
                setup_cycle = cycle;
            end
            if (i_apbo.pready) begin
                o_xfers++;
                exp = ref_word(idx);
                // pready belongs in the third cycle of a transfer
                if (cycle - setup_cycle != 2) begin
                    $display("** Error %s word %0d pready delay after setup: expected 2, actual %0d",
                             test_label(i_phase), idx, cycle - setup_cycle);
                    o_proto_errs++;
                end
                if (i_apbo.pslverr !== exp[32]) begin
                    $display("** Error %s word %0d pslverr: expected %0b, actual %0b",
                             test_label(i_phase), idx, exp[32], i_apbo.pslverr);
                    o_data_errs++;
                end
                if (!i_apbi.pwrite && i_apbo.prdata !== exp[31:0]) begin
                    $display("** Error %s word %0d prdata: expected %h, actual %h",
                             test_label(i_phase), idx, exp[31:0], i_apbo.prdata);
                    o_data_errs++;
                end
                if (i_apbi.pwrite && idx == 1) begin
                    fw_shadow = i_apbi.pwdata;
                end else if (i_apbi.pwrite && idx >= 4 && idx < 16) begin
                    scratch_shadow[4'(idx - 4)] = i_apbi.pwdata;
                end
            end
            ring = i_apbo.pready && i_apbi.pwrite && idx == 0;  // doorbell write completing
            if (i_irq !== ring) begin
                $display("** Error %s o_irq: expected %0b, actual %0b",
                         test_label(i_phase), ring, i_irq);
                o_data_errs++;
            end
            cfg_exp = '{soc_pnp_pkg::DESCR_TYPE_SLAVE, soc_pnp_pkg::DESCR_SIZE,
                        soc_pnp_pkg::VENDOR_ID, soc_pnp_pkg::PNP_DEVICE_ID,
                        i_mapinfo.slot_base, i_mapinfo.slot_end};
            if (i_devcfg !== cfg_exp) begin
                $display("** Error %s o_cfg: expected %h, actual %h",
                         test_label(i_phase), cfg_exp, i_devcfg);
                o_data_errs++;
            end
            cycle++;
        end
    end

endmodule

/* sim/pnp_tb.sv */
module pnp_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 20;
    localparam int LAST           = soc_pnp_pkg::LAST_WORD;

    logic                        clk;
    logic                        nrst;
    soc_pnp_pkg::apb_in_t        apbi;
    soc_pnp_pkg::apb_out_t       apbo;
    soc_pnp_pkg::map_info_t      mapinfo;
    soc_pnp_pkg::pnp_descr_vec_t cfg_vec;
    soc_pnp_pkg::dev_config_t    devcfg;
    logic                        irq;
    int                          phase;
    int                          seed;
    int                          issued;
    int                          timeouts;
    int                          xfers;
    int                          data_errs;
    int                          proto_errs;

    pnp_subsys_top UUT (
        .i_clk     (clk),
        .i_nrst    (nrst),
        .i_apbi    (apbi),
        .i_mapinfo (mapinfo),
        .i_cfg     (cfg_vec),
        .o_apbo    (apbo),
        .o_cfg     (devcfg),
        .o_irq     (irq)
    );

    pnp_checker u_checker (
        .i_clk        (clk),
        .i_nrst       (nrst),
        .i_phase      (phase),
        .i_apbi       (apbi),
        .i_apbo       (apbo),
        .i_irq        (irq),
        .i_cfg        (cfg_vec),
        .i_mapinfo    (mapinfo),
        .i_devcfg     (devcfg),
        .o_xfers      (xfers),
        .o_data_errs  (data_errs),
        .o_proto_errs (proto_errs)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;                                  // 4 ns period
        end
    end

    // starts on a falling edge and returns on the falling edge after completion
    task automatic apb_transfer(input logic wr, input int idx, input logic [31:0] wdata);
        int waited;
        apbi.paddr   = 32'(idx) << 2;
        apbi.psel    = 1'b1;
        apbi.penable = 1'b0;
        apbi.pwrite  = wr;
        apbi.pwdata  = wdata;
        issued++;
        @(negedge clk);
        apbi.penable = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!apbo.pready && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!apbo.pready) begin
            $display("timeout: word %0d got no pready within %0d cycles", idx, TIMEOUT_CYCLES);
            timeouts++;
        end
        @(negedge clk);
        apbi.psel    = 1'b0;                                // next call may start at once
        apbi.penable = 1'b0;
    endtask

    task automatic apb_write(input int idx, input logic [31:0] wdata);
        apb_transfer(1'b1, idx, wdata);
    endtask

    task automatic apb_read(input int idx);
        apb_transfer(1'b0, idx, 32'd0);
    endtask

    task automatic finish_run();
        int props_fails;
        int total;
        props_fails = UUT.u_ctrl.u_props.fail_count;
        total       = data_errs + proto_errs + props_fails + timeouts;
        if (xfers != issued) begin
            $display("checker saw %0d completed transfers but %0d were issued", xfers, issued);
            total++;
        end
        $display("transfers %0d, errors: data %0d, protocol %0d, assertion %0d, timeout %0d",
                 xfers, data_errs, proto_errs, props_fails, timeouts);
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    initial begin
        int          w;
        logic [31:0] r;
        seed     = 88;
        issued   = 0;
        timeouts = 0;
        phase    = 0;
        nrst     = 1'b0;
        apbi     = '0;
        mapinfo  = '{64'h0000_0000_ffff_f000, 64'h0000_0000_ffff_ffff};
        cfg_vec[0] = '{2'd1, 8'h20, 16'h1a01, 16'h0b01,
                       64'h0000_0008_8000_0000, 64'h0000_0008_8fff_ffff};
        cfg_vec[1] = '{2'd2, 8'h40, 16'h1a02, 16'h0b02,
                       64'h0000_0010_0000_1000, 64'h0000_0010_0000_1fff};
        cfg_vec[2] = '{2'd3, 8'h10, 16'h1a03, 16'h0b03,
                       64'h0000_0001_c000_0000, 64'h0000_0001_c00f_ffff};
        repeat (16) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);

        phase = 1;
        for (w = 0; w <= LAST; w++) begin
            apb_read(w);
        end

        phase = 2;
        apb_write(1, $random(seed));
        for (w = 4; w < 16; w++) begin
            apb_write(w, $random(seed));
        end
        apb_write(2, $random(seed));                        // read-only words
        apb_write(3, $random(seed));
        apb_write(16, $random(seed));
        apb_write(LAST, $random(seed));
        for (w = 1; w < 16; w++) begin
            apb_read(w);
        end
        apb_read(16);
        apb_read(LAST);

        phase = 3;
        for (w = soc_pnp_pkg::CFG_BASE_WORD; w <= LAST; w++) begin
            apb_read(w);
        end

        phase = 4;
        apb_write(0, $random(seed));
        apb_read(0);
        apb_write(5, $random(seed));
        apb_read(0);

        phase = 5;
        apb_read(LAST + 1);
        apb_read(1023);
        apb_write(512, $random(seed));
        repeat (16) begin                                   // mixed back-to-back traffic
            r = $random(seed);
            if (r[8]) begin
                apb_write(int'(r[5:0]), $random(seed));
            end else begin
                apb_read(int'(r[5:0]));
            end
        end
        finish_run();
    end

endmodule

/* project.f */
logic/soc_pnp_pkg.sv
logic/apb_slave_ctrl.sv
logic/pnp_regs.sv
logic/pnp_cfg_table.sv
logic/pnp_subsys_top.sv
sim/pnp_props.sv
sim/pnp_checker.sv
sim/pnp_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with verilator, run, then judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --assert --top-module pnp_tb -f project.f -o pnp_sim &&
    ./obj_dir/pnp_sim +verilator+error+limit+100 | tee "$LOG" ||
    { echo "build or simulation did not complete"; exit 1; }
grep -q "Simulation finished: FAIL" "$LOG" && exit 1 ||
    grep -q "Simulation finished: PASS" "$LOG"
